// File: build.f
hw/bru_pkg.sv
hw/bru_s1.sv
hw/bru_resolve.sv
hw/bru_top.sv
sim/bru_assert.sv
sim/bru_tb.sv

// File: hw/bru_pkg.sv
// ======================================================================
// Shared widths, opcodes and payload types of the branch unit.
// ======================================================================

package bru_pkg;

   // Data width of the operands and of the link register value.
   localparam int dw = 32;

   // Program counters are word addresses, so the two byte bits are gone.
   localparam int pcw = 30;

   // Width of the PC-relative offset field carried in the instruction.
   localparam int relw = 15;

   // ======================================================================
   // Branch opcodes
   // ======================================================================

   // The scheduler hands one of these to the unit with every issue.
   // The six conditional compares come first and the two jumps last.
   // Compares marked u are unsigned, all others are signed.
   typedef enum logic [2:0] {
      op_beq    = 3'd0,
      op_bne    = 3'd1,
      op_bgtu   = 3'd2,
      op_bgt    = 3'd3,
      op_bleu   = 3'd4,
      op_ble    = 3'd5,
      op_jmprel = 3'd6,
      op_jmpreg = 3'd7
   } bru_op_e;

   // ======================================================================
   // Payload structs
   // ======================================================================

   // One issued branch operation as it leaves the scheduler.
   // The struct is 113 bits wide in total.
   typedef struct packed {
      // Operation to perform.
      bru_op_e          op;
      // Word address of the branch instruction itself.
      logic [pcw-1:0]   pc;
      // First source register value, also the indirect jump target.
      logic [dw-1:0]    operand1;
      // Second source register value, used by the compares only.
      logic [dw-1:0]    operand2;
      // Signed word offset for conditional branches and op_jmprel.
      logic [relw-1:0]  rel15;
      // Set when the instruction sits in the first issue slot.
      logic             in_slot_1;
   } bru_req_t;

   // The operation after the first stage has classified it.
   // The request fields travel unchanged, followed by the decoded extras.
   typedef struct packed {
      bru_op_e          op;
      logic [pcw-1:0]   pc;
      logic [dw-1:0]    operand1;
      logic [dw-1:0]    operand2;
      logic [relw-1:0]  rel15;
      logic             in_slot_1;
      // One of the six conditional compares.
      logic             is_bcc;
      // Register-indirect jump, so the target comes from operand1.
      logic             is_breg;
      // Byte address of the instruction after the branch.
      logic [dw-1:0]    link_addr;
   } bru_dec_t;

   // Writeback result, valid for the single cycle of the wb pulse.
   typedef struct packed {
      // Fetch must restart at target_pc.
      logic             redirect;
      // Word address to fetch from when redirect is set.
      logic [pcw-1:0]   target_pc;
      // The link register is written with link_data.
      logic             link_we;
      logic [dw-1:0]    link_data;
      // Slot flag copied from the issue, for the delay slot logic.
      logic             in_slot_1;
   } bru_result_t;

endpackage

// File: hw/bru_resolve.sv
`timescale 1ns/1ps

// ======================================================================
// Resolve stage of the branch unit.
// ======================================================================

// The branch condition and both candidate targets are worked out
// combinationally from the decoded operation. The chosen result is then
// captured in one register stage, so the writeback pulse appears exactly
// one cycle after the issue strobe. There is no back-pressure, and every
// valid input becomes one valid output.
module bru_resolve (
   input  logic                  clk,
   input  logic                  rst_n,
   // Decoded operation from the first stage.
   input  logic                  dec_valid,
   input  bru_pkg::bru_dec_t     dec,
   // Writeback pulse and its result.
   output logic                  wb_valid,
   output bru_pkg::bru_result_t  wb
);

   // ======================================================================
   // Operand compare
   // ======================================================================

   // Compare results shared by the condition case below.
   logic op_eq;
   logic op_gtu;
   logic op_gt;

   // Outcome of the branch condition.
   logic taken;

   // Equality is the same for signed and unsigned operands.
   assign op_eq  = (dec.operand1 == dec.operand2);

   // Greater-than in both flavours.
   // The less-or-equal compares are simply their inverses.
   assign op_gtu = (dec.operand1 > dec.operand2);
   assign op_gt  = ($signed(dec.operand1) > $signed(dec.operand2));

   // Pick the condition for the opcode.
   // Both jumps are unconditional and count as taken.
   always_comb begin
      taken = 1'b0;
      case (dec.op)
         bru_pkg::op_beq:    taken = op_eq;
         bru_pkg::op_bne:    taken = ~op_eq;
         bru_pkg::op_bgtu:   taken = op_gtu;
         bru_pkg::op_bgt:    taken = op_gt;
         bru_pkg::op_bleu:   taken = ~op_gtu;
         bru_pkg::op_ble:    taken = ~op_gt;
         bru_pkg::op_jmprel: taken = 1'b1;
         bru_pkg::op_jmpreg: taken = 1'b1;
         default:            taken = 1'b0;
      endcase
   end

   // ======================================================================
   // Target address
   // ======================================================================

   // Offset widened to the PC width with its sign bit copied upwards.
   logic [bru_pkg::pcw-1:0] rel_ext;

   // Candidate targets for the two addressing modes.
   logic [bru_pkg::pcw-1:0] rel_target;
   logic [bru_pkg::pcw-1:0] reg_target;

   // Sign extension of the word offset.
   assign rel_ext = {{(bru_pkg::pcw - bru_pkg::relw){dec.rel15[bru_pkg::relw-1]}},
                     dec.rel15};

   // Relative target in words.
   // The sum drops its carry, so it wraps modulo the PC range.
   assign rel_target = dec.pc + rel_ext;

   // The register holds a byte address; the two low bits are dropped
   // and no alignment check is made.
   assign reg_target = dec.operand1[bru_pkg::dw-1 -: bru_pkg::pcw];

   // ======================================================================
   // Result assembly
   // ======================================================================

   // Result for the current decoded operation, before the register.
   bru_pkg::bru_result_t res;

   // The class flags from stage 1 steer the muxes, so the opcode is not
   // decoded a second time here.
   always_comb begin
      // Jumps always redirect, compares only when their condition holds.
      res.redirect  = taken;
      // Only op_jmpreg takes its target from a register.
      res.target_pc = dec.is_breg ? reg_target : rel_target;
      // Both jumps link, the compares never do.
      res.link_we   = ~dec.is_bcc;
      res.link_data = dec.link_addr;
      res.in_slot_1 = dec.in_slot_1;
   end

   // ======================================================================
   // Writeback register
   // ======================================================================

   // The pulse follows the input strobe by exactly one cycle.
   // The result is loaded only with a valid operation, so an idle cycle
   // leaves the previous value in place while wb_valid is low.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         wb       <= '0;
      end else begin
         wb_valid <= dec_valid;
         if (dec_valid) begin
            wb <= res;
         end
      end
   end

endmodule

// File: hw/bru_s1.sv
`timescale 1ns/1ps

// ======================================================================
// First stage of the branch unit.
// ======================================================================

// This stage is purely combinational and adds no cycle of latency.
// It sorts the opcode into the two classes that the resolve stage needs
// and forms the link address, so the next stage never has to decode
// the opcode again for its muxes.
module bru_s1 (
   // Issue strobe and operation from the scheduler.
   input  logic               issue_valid,
   input  bru_pkg::bru_req_t  issue,
   // Classified operation towards the resolve stage.
   output logic               dec_valid,
   output bru_pkg::bru_dec_t  dec
);

   // Word address of the next sequential instruction.
   logic [bru_pkg::pcw-1:0] pc_next;

   // Class flags derived from the opcode.
   logic is_bcc;
   logic is_breg;

   // The strobe passes straight on, since this stage holds no state.
   assign dec_valid = issue_valid;

   // The next PC wraps at the top of the word address space.
   assign pc_next = issue.pc + bru_pkg::pcw'(1);

   // Decode the opcode into the branch classes.
   // Only op_jmprel reaches the default arm.
   always_comb begin
      is_bcc  = 1'b0;
      is_breg = 1'b0;
      case (issue.op)
         bru_pkg::op_beq,
         bru_pkg::op_bne,
         bru_pkg::op_bgtu,
         bru_pkg::op_bgt,
         bru_pkg::op_bleu,
         bru_pkg::op_ble: begin
            is_bcc = 1'b1;
         end
         bru_pkg::op_jmpreg: begin
            is_breg = 1'b1;
         end
         // PC-relative jump, neither flag.
         default: begin
            is_bcc  = 1'b0;
            is_breg = 1'b0;
         end
      endcase
   end

   // Assemble the decoded operation.
   always_comb begin
      // Request fields pass through unchanged.
      dec.op        = issue.op;
      dec.pc        = issue.pc;
      dec.operand1  = issue.operand1;
      dec.operand2  = issue.operand2;
      dec.rel15     = issue.rel15;
      dec.in_slot_1 = issue.in_slot_1;
      // Classes found above.
      dec.is_bcc    = is_bcc;
      dec.is_breg   = is_breg;
      // The link value is a byte address, so two zero bits go below.
      dec.link_addr = {pc_next, 2'b00};
   end

endmodule

// File: hw/bru_top.sv
`timescale 1ns/1ps

// ======================================================================
// Top level of the branch unit.
// ======================================================================

// The unit is two stages deep in logic but one cycle deep in time.
// The first stage classifies the operation without a register, and the
// resolve stage evaluates it and registers the writeback result.
module bru_top (
   input  logic                  clk,
   input  logic                  rst_n,
   // One strobe per issued branch, with its operation.
   input  logic                  issue_valid,
   input  bru_pkg::bru_req_t     issue,
   // One pulse per issue, a cycle later.
   output logic                  wb_valid,
   output bru_pkg::bru_result_t  wb
);

   // Decoded operation between the two stages.
   logic               dec_valid;
   bru_pkg::bru_dec_t  dec;

   // ======================================================================
   // Stage 1, combinational classification
   // ======================================================================

   bru_s1 u_s1 (
      .issue_valid (issue_valid),
      .issue       (issue),
      .dec_valid   (dec_valid),
      .dec         (dec)
   );

   // ======================================================================
   // Resolve stage, one register
   // ======================================================================

   // This stage sets the total latency of the unit to one cycle.
   bru_resolve u_resolve (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec_valid (dec_valid),
      .dec       (dec),
      .wb_valid  (wb_valid),
      .wb        (wb)
   );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the branch unit testbench with Verilator, runs it, and decides
# the outcome from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=bru_sim
log_file=sim.log
pass_text="PASS: all tests"

verilator --binary --timing --assert \
   -Mdir "$build_dir" \
   --top-module bru_tb \
   -f build.f \
   -o "$sim_name"
status=$?
if [ "$status" -ne 0 ]; then
   echo "run_sim: Verilator build failed with status $status"
   exit 1
fi

"./$build_dir/$sim_name" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
   echo "run_sim: simulation exited with status $status"
   exit 1
fi

if grep -qxF "$pass_text" "$log_file"; then
   echo "run_sim: simulation passed"
   exit 0
fi

echo "run_sim: simulation failed, see $log_file"
exit 1

// File: sim/bru_assert.sv
`timescale 1ns/1ps

// ======================================================================
// Protocol checks on the branch unit boundary.
// ======================================================================

module bru_assert (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  issue_valid,
   input logic                  wb_valid,
   input bru_pkg::bru_result_t  wb
);

   // A reset cycle leaves no pulse behind it.
   reset_quiet: assert property (@(posedge clk) !rst_n |=> !wb_valid)
      else $error("wb_valid high in the cycle after a reset cycle");

   // Out of reset the pulse is the issue strobe one cycle late.
   pulse_follows_issue: assert property (
      @(posedge clk) rst_n |=> (wb_valid == $past(issue_valid)))
      else $error("wb_valid does not follow issue_valid by one cycle");

   // Only jumps link, and jumps always redirect.
   link_needs_redirect: assert property (
      @(posedge clk) (wb_valid && wb.link_we) |-> wb.redirect)
      else $error("link_we set without redirect");

endmodule

bind bru_top bru_assert u_assert (
   .clk         (clk),
   .rst_n       (rst_n),
   .issue_valid (issue_valid),
   .wb_valid    (wb_valid),
   .wb          (wb)
);

// File: sim/bru_tb.sv
`timescale 1ns/1ps

// ======================================================================
// Testbench for the branch unit.
// ======================================================================

// A directed table runs first, then a random phase drawn from an LFSR.
// Every issue pushes its expected result, and a monitor on the falling
// edge pops one entry for each writeback pulse.
module bru_tb;

   localparam int clk_period_ns = 20;
   localparam int n_rows = 21;
   localparam int n_random = 200;
   localparam int watchdog_ns = (n_rows + n_random + 50) * clk_period_ns;

   // Two-state clock, so time zero brings no edge out of an unknown value.
   bit                    clk;
   logic                  rst_n;
   logic                  issue_valid;
   bru_pkg::bru_req_t     issue;
   logic                  wb_valid;
   bru_pkg::bru_result_t  wb;

   // Directed stimulus and the results worked out by hand for it.
   bru_pkg::bru_req_t     row_req [n_rows];
   bru_pkg::bru_result_t  row_exp [n_rows];

   // Results still owed by the DUT, oldest first, with a label each.
   bru_pkg::bru_result_t  exp_q [$];
   string                 label_q [$];

   // What the pulse and the reset state should look like this cycle.
   logic exp_wb_valid;
   logic was_reset;

   logic [31:0] lfsr_state;
   int          err_count;
   int          tests_run;
   int          tests_failed;

   bru_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue       (issue),
      .wb_valid    (wb_valid),
      .wb          (wb)
   );

   always #(clk_period_ns / 2) clk = ~clk;

   // ======================================================================
   // Random numbers
   // ======================================================================

   // Right-shifting Galois LFSR with taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // Collects n bits, one LFSR step per bit.
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // ======================================================================
   // Reference model
   // ======================================================================

   // Expected writeback for one issue, straight from the branch rules.
   function automatic bru_pkg::bru_result_t model_result(input bru_pkg::bru_req_t r);
      bru_pkg::bru_result_t     res;
      logic [31:0]              a_biased;
      logic [31:0]              b_biased;
      logic [bru_pkg::pcw-1:0]  offset;
      logic                     taken;
      // Flipping the sign bits maps signed order onto unsigned order.
      a_biased = r.operand1 ^ 32'h8000_0000;
      b_biased = r.operand2 ^ 32'h8000_0000;
      offset = {{15{r.rel15[14]}}, r.rel15};
      case (r.op)
         bru_pkg::op_beq:  taken = (r.operand1 == r.operand2);
         bru_pkg::op_bne:  taken = (r.operand1 != r.operand2);
         bru_pkg::op_bgtu: taken = (r.operand2 < r.operand1);
         bru_pkg::op_bgt:  taken = (b_biased < a_biased);
         bru_pkg::op_bleu: taken = (r.operand1 <= r.operand2);
         bru_pkg::op_ble:  taken = (a_biased <= b_biased);
         default:          taken = 1'b1;
      endcase
      res.redirect = taken;
      res.link_we = (r.op == bru_pkg::op_jmprel) || (r.op == bru_pkg::op_jmpreg);
      res.target_pc = (r.op == bru_pkg::op_jmpreg) ? r.operand1[31:2] : r.pc + offset;
      res.link_data = {r.pc + 30'd1, 2'b00};
      res.in_slot_1 = r.in_slot_1;
      return res;
   endfunction

   // ======================================================================
   // Stimulus helpers
   // ======================================================================

   task automatic set_row(input int i, input bru_pkg::bru_op_e op, input logic [29:0] pc,
                          input logic [31:0] a, input logic [31:0] b, input logic [14:0] rel,
                          input logic slot, input logic redirect, input logic [29:0] target,
                          input logic link_we, input logic [31:0] link_data);
      row_req[i] = '{op, pc, a, b, rel, slot};
      row_exp[i] = '{redirect, target, link_we, link_data, slot};
   endtask

   // Drives one operation on the next rising edge and records its result.
   task automatic issue_op(input string kind, input int idx, input bru_pkg::bru_req_t r,
                           input bru_pkg::bru_result_t want);
      bru_pkg::bru_op_e op_v;
      op_v = r.op;
      @(posedge clk);
      issue_valid <= 1'b1;
      issue <= r;
      exp_q.push_back(want);
      label_q.push_back($sformatf("%s %0d %s", kind, idx, op_v.name()));
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      issue_valid <= 1'b0;
   endtask

   task automatic check_field(input string name, input logic [31:0] want,
                              input logic [31:0] got, inout bit ok);
      if (want !== got) begin
         $display("Mismatch at %0d ns: %s expected 0x%0h, actual 0x%0h",
                  $time, name, want, got);
         err_count++;
         ok = 1'b0;
      end
   endtask

   // ======================================================================
   // Monitor
   // ======================================================================

   // The pulse is due one edge after an issue was sampled out of reset.
   always @(posedge clk) begin
      exp_wb_valid <= rst_n && issue_valid;
      was_reset <= !rst_n;
   end

   // Outputs settle half a cycle after the edge, so they are checked here.
   always @(negedge clk) begin
      bru_pkg::bru_result_t want;
      string                label;
      bit                   ok;
      if (wb_valid !== exp_wb_valid) begin
         $display("Mismatch at %0d ns: wb_valid expected %b, actual %b",
                  $time, exp_wb_valid, wb_valid);
         err_count++;
      end
      if (was_reset && (wb !== '0)) begin
         $display("Mismatch at %0d ns: wb expected 0x0, actual 0x%0h", $time, wb);
         err_count++;
      end
      if (wb_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("Error at %0d ns: a writeback pulse came with no issue outstanding",
                     $time);
            err_count++;
         end else begin
            want = exp_q.pop_front();
            label = label_q.pop_front();
            ok = 1'b1;
            check_field("redirect", 32'(want.redirect), 32'(wb.redirect), ok);
            check_field("target_pc", 32'(want.target_pc), 32'(wb.target_pc), ok);
            check_field("link_we", 32'(want.link_we), 32'(wb.link_we), ok);
            check_field("link_data", want.link_data, wb.link_data, ok);
            check_field("in_slot_1", 32'(want.in_slot_1), 32'(wb.in_slot_1), ok);
            tests_run++;
            if (ok) begin
               $display("%s passed", label);
            end else begin
               $display("%s FAILED", label);
               tests_failed++;
            end
         end
      end
   end

   // ======================================================================
   // Test sequence
   // ======================================================================

   initial begin
      bru_pkg::bru_req_t req;
      logic [31:0]       bits;
      clk = 1'b0;
      rst_n = 1'b0;
      issue_valid = 1'b0;
      issue = '0;
      exp_wb_valid = 1'b0;
      was_reset = 1'b0;
      lfsr_state = 32'd69386;
      err_count = 0;
      tests_run = 0;
      tests_failed = 0;

      // Compares use pc 0x1000 with offset 4 unless they probe the target.
      set_row(0,  bru_pkg::op_beq,    30'h100, 32'h5, 32'h5, 15'h0010, 1'b0,
              1'b1, 30'h110, 1'b0, 32'h404);
      set_row(1,  bru_pkg::op_beq,    30'h100, 32'h5, 32'h6, 15'h0010, 1'b1,
              1'b0, 30'h110, 1'b0, 32'h404);
      set_row(2,  bru_pkg::op_bne,    30'h200, 32'h5, 32'h6, 15'h7FF0, 1'b0,
              1'b1, 30'h1F0, 1'b0, 32'h804);
      set_row(3,  bru_pkg::op_bne,    30'h200, 32'h7, 32'h7, 15'h7FF0, 1'b1,
              1'b0, 30'h1F0, 1'b0, 32'h804);
      set_row(4,  bru_pkg::op_bgtu,   30'h1000, 32'hFFFF_FFFF, 32'h1, 15'h0004, 1'b0,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(5,  bru_pkg::op_bgtu,   30'h1000, 32'h1, 32'hFFFF_FFFF, 15'h0004, 1'b1,
              1'b0, 30'h1004, 1'b0, 32'h4004);
      set_row(6,  bru_pkg::op_bgt,    30'h1000, 32'hFFFF_FFFF, 32'h1, 15'h0004, 1'b0,
              1'b0, 30'h1004, 1'b0, 32'h4004);
      set_row(7,  bru_pkg::op_bgt,    30'h1000, 32'h1, 32'hFFFF_FFFF, 15'h0004, 1'b1,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(8,  bru_pkg::op_bgt,    30'h1000, 32'h7FFF_FFFF, 32'h8000_0000, 15'h0004, 1'b0,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(9,  bru_pkg::op_bleu,   30'h1000, 32'hFFFF_FFFF, 32'h1, 15'h0004, 1'b1,
              1'b0, 30'h1004, 1'b0, 32'h4004);
      set_row(10, bru_pkg::op_bleu,   30'h1000, 32'h1, 32'hFFFF_FFFF, 15'h0004, 1'b0,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(11, bru_pkg::op_bleu,   30'h1000, 32'h3, 32'h3, 15'h0004, 1'b1,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(12, bru_pkg::op_ble,    30'h1000, 32'hFFFF_FFFF, 32'h1, 15'h0004, 1'b0,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      set_row(13, bru_pkg::op_ble,    30'h1000, 32'h1, 32'hFFFF_FFFF, 15'h0004, 1'b1,
              1'b0, 30'h1004, 1'b0, 32'h4004);
      set_row(14, bru_pkg::op_ble,    30'h1000, 32'h8000_0000, 32'h7FFF_FFFF, 15'h0004, 1'b0,
              1'b1, 30'h1004, 1'b0, 32'h4004);
      // Jumps with positive, most negative and wrapping offsets.
      set_row(15, bru_pkg::op_jmprel, 30'h2000, 32'h0, 32'h0, 15'h0100, 1'b0,
              1'b1, 30'h2100, 1'b1, 32'h8004);
      set_row(16, bru_pkg::op_jmprel, 30'h2000, 32'h0, 32'h0, 15'h4000, 1'b1,
              1'b1, 30'h3FFF_E000, 1'b1, 32'h8004);
      set_row(17, bru_pkg::op_jmprel, 30'h3FFF_FFF0, 32'h0, 32'h0, 15'h0020, 1'b0,
              1'b1, 30'h10, 1'b1, 32'hFFFF_FFC4);
      set_row(18, bru_pkg::op_jmprel, 30'h3FFF_FFFF, 32'h0, 32'h0, 15'h0000, 1'b1,
              1'b1, 30'h3FFF_FFFF, 1'b1, 32'h0);
      set_row(19, bru_pkg::op_jmpreg, 30'h3000, 32'hABCF, 32'h0, 15'h1234, 1'b0,
              1'b1, 30'h2AF3, 1'b1, 32'hC004);
      set_row(20, bru_pkg::op_jmpreg, 30'h3000, 32'hFFFF_FFFC, 32'h0, 15'h0000, 1'b1,
              1'b1, 30'h3FFF_FFFF, 1'b1, 32'hC004);

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      idle_cycle();
      idle_cycle();

      // Directed rows go out back to back.
      for (int i = 0; i < n_rows; i++) begin
         issue_op("directed", i, row_req[i], row_exp[i]);
      end
      idle_cycle();

      // Random operations, with an idle gap about one time in sixteen.
      for (int n = 0; n < n_random; n++) begin
         take_bits(4, bits);
         if (bits[3:0] == 4'd0) begin
            idle_cycle();
         end
         take_bits(3, bits);
         req.op = bru_pkg::bru_op_e'(bits[2:0]);
         take_bits(30, bits);
         req.pc = bits[29:0];
         take_bits(32, bits);
         req.operand1 = bits;
         take_bits(32, bits);
         req.operand2 = bits;
         // Equal operands are rare at random, so force some.
         take_bits(2, bits);
         if (bits[1:0] == 2'd0) begin
            req.operand2 = req.operand1;
         end
         take_bits(15, bits);
         req.rel15 = bits[14:0];
         take_bits(1, bits);
         req.in_slot_1 = bits[0];
         issue_op("random", n, req, model_result(req));
      end
      repeat (3) idle_cycle();

      if (exp_q.size() != 0) begin
         $display("Error: %0d expected writeback pulses never arrived", exp_q.size());
         err_count++;
      end
      $display("Summary: %0d tests checked, %0d failed, %0d errors",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Ends a run that stalls well past the length of all tests.
   initial begin
      #(watchdog_ns);
      $display("Error: timeout, the run did not finish within %0d ns", watchdog_ns);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
